//--- int_core.f
design/int_core_pkg.sv
design/regfile.sv
design/inst_decode.sv
design/exec_stage.sv
design/int_core.sv
tb/int_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= int_core_tb
FILELIST  ?= int_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Regression failed

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard design/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/int_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_core_tb;

	import int_core_pkg::*;

	localparam int period = 100;
	localparam int n_rand = 512;
	localparam int n_dep = 256;
	localparam int n_x0 = 128;
	localparam int n_ill = 64;
	localparam int n_cycles = 2 + n_rand + n_dep + n_x0 + 2 * n_ill + 2 + 4;
	localparam logic [31:0] seed = 32'h0bef_d76e;

	logic      clk;
	logic      rst;
	logic      inst_valid;
	inst_t     inst;
	logic      illegal;
	logic      wb_valid;
	reg_addr_t wb_rd;
	word_t     wb_data;
	word_t     regs [nregs];

	logic [31:0] rng_state;
	word_t       model_regs [nregs];
	bit          exp_en_q [$];
	reg_addr_t   exp_rd_q [$];
	word_t       exp_data_q [$];
	int          n_checks = 0;
	int          n_errors = 0;
	int          n_issued = 0;

	int_core int_core_inst (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.illegal    (illegal),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.regs       (regs)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		#((n_cycles + 50) * period);
		$display("Timeout: the run did not end within %0d cycles", n_cycles + 50);
		$display("Regression failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Reads see the writeback that is still in flight
	function automatic word_t model_read(input reg_addr_t a);
		word_t v;
		if (a == 5'd0)
			v = '0;
		else if (exp_en_q.size() > 0 && exp_en_q[0] && exp_rd_q[0] == a)
			v = exp_data_q[0];
		else
			v = model_regs[a];
		return v;
	endfunction

	function automatic alu_op_t op_for(input logic [2:0] f3, input logic alt);
		case (f3)
			f3_add:  return alt ? alu_sub : alu_add;
			f3_sll:  return alu_sll;
			f3_slt:  return alu_slt;
			f3_sltu: return alu_sltu;
			f3_xor:  return alu_xor;
			f3_srl:  return alt ? alu_sra : alu_srl;
			f3_or:   return alu_or;
			default: return alu_and;
		endcase
	endfunction

	function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_and:  return a & b;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_sll:  return a << b[5:0];
			alu_srl:  return a >> b[5:0];
			alu_sra:  return word_t'($signed(a) >>> b[5:0]);
			alu_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			alu_sltu: return (a < b) ? 64'd1 : 64'd0;
			default:  return b;
		endcase
	endfunction

	function automatic void model_inst(input inst_t w, output bit legal, output word_t res);
		logic [2:0] f3;
		logic [5:0] f6;
		word_t      a;
		word_t      b;
		f3 = w[14:12];
		f6 = w[31:26];
		a = model_read(w[19:15]);
		b = model_read(w[24:20]);
		legal = 1'b0;
		res = '0;
		case (w[6:0])
			op_op: begin
				legal = (w[31:25] == 7'b0000000) ||
					(w[31:25] == 7'b0100000 && (f3 == f3_add || f3 == f3_srl));
				res = alu_ref(op_for(f3, w[30]), a, b);
			end
			op_imm: begin
				if (f3 == f3_sll || f3 == f3_srl) begin
					legal = (f6 == 6'b000000) || (f3 == f3_srl && f6 == 6'b010000);
					res = alu_ref(op_for(f3, f6 == 6'b010000), a, {58'd0, w[25:20]});
				end else begin
					legal = 1'b1;
					res = alu_ref(op_for(f3, 1'b0), a, {{52{w[31]}}, w[31:20]});
				end
			end
			op_lui: begin
				legal = 1'b1;
				res = {{32{w[31]}}, w[31:12], 12'd0};
			end
			default: legal = 1'b0;
		endcase
	endfunction

	// Small register indices make sources often hit a recent rd
	function automatic inst_t gen_inst(input bit dep, input reg_addr_t last_rd);
		logic [31:0] r;
		logic [31:0] s;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r = next_rand();
		s = next_rand();
		rd = {2'b00, r[2:0]};
		rs1 = dep ? last_rd : {2'b00, r[5:3]};
		rs2 = (dep && r[9]) ? last_rd : {2'b00, r[8:6]};
		f3 = r[12:10];
		f7 = (r[13] && (f3 == f3_add || f3 == f3_srl)) ? 7'b0100000 : 7'b0000000;
		case (r[16:14])
			3'd0, 3'd1, 3'd2: return {f7, rs2, rs1, f3, rd, op_op};
			3'd3, 3'd4, 3'd5: begin
				if (f3 == f3_sll || f3 == f3_srl)
					return {f7[6:1], s[5:0], rs1, f3, rd, op_imm};
				return {s[11:0], rs1, f3, rd, op_imm};
			end
			3'd6:    return {s[19:0], rd, op_lui};
			default: return s; // Raw word that is mostly illegal
		endcase
	endfunction

	function automatic inst_t gen_illegal();
		logic [31:0] r;
		logic [31:0] s;
		r = next_rand();
		s = next_rand();
		case (s[1:0])
			2'd0:    return {r[31:7], 7'b0000011};                              // Load
			2'd1:    return {7'b0000001, r[24:12], r[11:7], op_op};            // M extension
			2'd2:    return {6'b010000, r[25:15], 3'b001, r[11:7], op_imm};   // SLLI with SRA funct6
			default: return {6'b000001, r[25:15], 3'b101, r[11:7], op_imm};
		endcase
	endfunction

	task automatic compare_regs();
		for (int i = 0; i < nregs; i++)
			check_word($sformatf("x%0d", i), regs[i], model_regs[i]);
	endtask

	// Checks the writeback of the previous cycle, then commits it to the model
	task automatic retire(input bit do_regs);
		bit        en;
		reg_addr_t a;
		word_t     d;
		en = 1'b0;
		a = '0;
		d = '0;
		if (do_regs)
			compare_regs();
		if (exp_en_q.size() > 0) begin
			en = exp_en_q.pop_front();
			a = exp_rd_q.pop_front();
			d = exp_data_q.pop_front();
		end
		check_flag("wb_valid", wb_valid, en);
		if (en) begin
			check_addr("wb_rd", wb_rd, a);
			check_word("wb_data", wb_data, d);
			if (a != 5'd0)
				model_regs[a] = d;
		end
		check_word("x0", regs[0], '0);
	endtask

	task automatic issue(input bit valid, input inst_t w);
		bit    legal;
		word_t res;
		@(posedge clk);
		inst_valid <= valid;
		inst <= w;
		model_inst(w, legal, res);
		@(negedge clk);
		check_flag("illegal", illegal, valid && !legal);
		retire(valid && (n_issued % 64 == 0));
		exp_en_q.push_back(valid && legal);
		exp_rd_q.push_back(w[11:7]);
		exp_data_q.push_back(res);
		if (valid)
			n_issued++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		int errs;
		errs = n_errors - errs_before;
		$display("Test %-10s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAIL", errs);
	endtask

	initial begin
		int          e0;
		logic [31:0] r;
		inst_t       w;
		reg_addr_t   last_rd;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		rng_state = seed;
		last_rd = '0;
		for (int i = 0; i < nregs; i++)
			model_regs[i] = '0;

		repeat (2) @(posedge clk);
		rst <= 1'b0;

		e0 = n_errors;
		for (int i = 0; i < n_rand; i++) begin
			r = next_rand();
			issue(r[3:0] != 4'd0, gen_inst(1'b0, '0)); // Occasional bubble
		end
		report_test("random", e0);

		e0 = n_errors;
		for (int i = 0; i < n_dep; i++) begin
			w = gen_inst(1'b1, last_rd);
			issue(1'b1, w);
			last_rd = w[11:7];
		end
		report_test("dependent", e0);

		e0 = n_errors;
		for (int i = 0; i < n_x0; i++) begin
			w = gen_inst(1'b0, '0);
			r = next_rand();
			w[11:7] = 5'd0;
			if (r[0])
				w[19:15] = 5'd0;
			if (r[1])
				w[24:20] = 5'd0;
			issue(1'b1, w);
		end
		report_test("x0", e0);

		e0 = n_errors;
		for (int i = 0; i < n_ill; i++) begin
			issue(1'b1, gen_illegal());
			issue(1'b1, gen_inst(1'b0, '0));
		end
		report_test("illegal", e0);

		// Two bubbles let the last write land before the final sweep
		e0 = n_errors;
		issue(1'b0, '0);
		issue(1'b0, '0);
		compare_regs();
		report_test("final_regs", e0);

		// Reset over live register contents with a valid ADDI x9 presented
		e0 = n_errors;
		@(posedge clk);
		rst <= 1'b1;
		inst_valid <= 1'b1;
		inst <= {12'h7ff, 5'd1, f3_add, 5'd9, op_imm};
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		inst_valid <= 1'b0;
		@(negedge clk);
		check_flag("wb_valid", wb_valid, 1'b0);
		for (int i = 0; i < nregs; i++)
			model_regs[i] = '0;
		compare_regs();
		report_test("reset", e0);

		$display("Summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/int_core.sv
`timescale 1ns/1ps
`default_nettype none

module int_core (
	input  wire                     clk,
	input  wire                     rst,

	input  wire                     inst_valid,
	input  int_core_pkg::inst_t     inst,
	output logic                    illegal,

	output logic                    wb_valid,
	output int_core_pkg::reg_addr_t wb_rd,
	output int_core_pkg::word_t     wb_data,

	output int_core_pkg::word_t     regs [int_core_pkg::nregs]
);

	import int_core_pkg::*;

	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	logic      uses_rs1;
	logic      uses_rs2;
	word_t     imm;
	logic      use_imm;
	alu_op_t   alu_op;
	logic      wr_en;
	word_t     rdata1;
	word_t     rdata2;

	inst_decode inst_decode_inst (
		.inst_valid (inst_valid),
		.inst       (inst),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.uses_rs1   (uses_rs1),
		.uses_rs2   (uses_rs2),
		.imm        (imm),
		.use_imm    (use_imm),
		.alu_op     (alu_op),
		.wr_en      (wr_en),
		.illegal    (illegal)
	);

	// Writeback port closes the loop from stage two
	regfile regfile_inst (
		.clk     (clk),
		.rst     (rst),
		.w_addr  (wb_rd),
		.w_data  (wb_data),
		.w_ena   (wb_valid),
		.r_addr1 (rs1),
		.r_ena1  (uses_rs1),
		.r_data1 (rdata1),
		.r_addr2 (rs2),
		.r_ena2  (uses_rs2),
		.r_data2 (rdata2),
		.regs    (regs)
	);

	exec_stage exec_stage_inst (
		.clk     (clk),
		.rst     (rst),
		.rdata1  (rdata1),
		.rdata2  (rdata2),
		.imm     (imm),
		.use_imm (use_imm),
		.alu_op  (alu_op),
		.rd      (rd),
		.wr_en   (wr_en),
		.wb_en   (wb_valid),
		.wb_addr (wb_rd),
		.wb_data (wb_data)
	);

endmodule

`default_nettype wire

//--- design/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  wire                     clk,
	input  wire                     rst,

	input  int_core_pkg::word_t     rdata1,
	input  int_core_pkg::word_t     rdata2,
	input  int_core_pkg::word_t     imm,
	input  wire                     use_imm,
	input  int_core_pkg::alu_op_t   alu_op,
	input  int_core_pkg::reg_addr_t rd,
	input  wire                     wr_en,

	output logic                    wb_en,
	output int_core_pkg::reg_addr_t wb_addr,
	output int_core_pkg::word_t     wb_data
);

	import int_core_pkg::*;

	word_t     op_b;
	word_t     a_q;
	word_t     b_q;
	alu_op_t   op_q;
	reg_addr_t rd_q;
	logic      en_q;
	logic [5:0] shamt;
	word_t     result;

	assign op_b = use_imm ? imm : rdata2;

	// Pipeline register
	always_ff @(posedge clk) begin
		a_q  <= rdata1;
		b_q  <= op_b;
		op_q <= alu_op;
		rd_q <= rd;
	end

	always_ff @(posedge clk) begin
		if (rst)
			en_q <= 1'b0;
		else
			en_q <= wr_en;
	end

	assign shamt = b_q[5:0];

	always_comb begin
		case (op_q)
			alu_add:    result = a_q + b_q;
			alu_sub:    result = a_q - b_q;
			alu_and:    result = a_q & b_q;
			alu_or:     result = a_q | b_q;
			alu_xor:    result = a_q ^ b_q;
			alu_sll:    result = a_q << shamt;
			alu_srl:    result = a_q >> shamt;
			alu_sra:    result = word_t'($signed(a_q) >>> shamt);
			alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a_q) < $signed(b_q)};
			alu_sltu:   result = {{(xlen-1){1'b0}}, a_q < b_q};
			alu_pass_b: result = b_q; // LUI
			default:    result = '0;
		endcase
	end

	assign wb_en   = en_q;
	assign wb_addr = rd_q;
	assign wb_data = result;

endmodule

`default_nettype wire

//--- design/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
	input  wire                     inst_valid,
	input  int_core_pkg::inst_t     inst,

	output int_core_pkg::reg_addr_t rs1,
	output int_core_pkg::reg_addr_t rs2,
	output int_core_pkg::reg_addr_t rd,
	output logic                    uses_rs1,
	output logic                    uses_rs2,
	output int_core_pkg::word_t     imm,
	output logic                    use_imm,
	output int_core_pkg::alu_op_t   alu_op,
	output logic                    wr_en,
	output logic                    illegal
);

	import int_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;
	word_t      i_imm;
	word_t      sh_imm;
	word_t      u_imm;
	logic       legal;

	// Shared by OP and OP-IMM where alt picks SUB or SRA
	function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			f3_add:  op = alt ? alu_sub : alu_add;
			f3_sll:  op = alu_sll;
			f3_slt:  op = alu_slt;
			f3_sltu: op = alu_sltu;
			f3_xor:  op = alu_xor;
			f3_srl:  op = alt ? alu_sra : alu_srl;
			f3_or:   op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign funct6 = inst[31:26];

	assign rd  = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];

	assign i_imm  = {{52{inst[31]}}, inst[31:20]};
	assign sh_imm = {58'b0, inst[25:20]};                 // 6-bit shamt
	assign u_imm  = {{32{inst[31]}}, inst[31:12], 12'b0};

	always_comb begin
		legal    = 1'b0;
		alu_op   = alu_add;
		imm      = i_imm;
		use_imm  = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			op_op: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				alu_op   = f3_to_op(funct3, funct7 == f7_alt);
				legal    = (funct7 == f7_base) ||
					((funct7 == f7_alt) && ((funct3 == f3_add) || (funct3 == f3_srl)));
			end
			op_imm: begin
				uses_rs1 = 1'b1;
				use_imm  = 1'b1;
				legal    = 1'b1;
				alu_op   = f3_to_op(funct3, (funct3 == f3_srl) && (funct6 == f6_alt));
				if (funct3 == f3_sll) begin
					imm   = sh_imm;
					legal = (funct6 == f6_base);
				end else if (funct3 == f3_srl) begin
					imm   = sh_imm;
					legal = (funct6 == f6_base) || (funct6 == f6_alt);
				end
			end
			op_lui: begin
				use_imm = 1'b1;
				imm     = u_imm;
				alu_op  = alu_pass_b;
				legal   = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal = inst_valid && !legal;
	assign wr_en   = inst_valid && legal; // x0 writes are dropped in the register file

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire                     clk,
	input  wire                     rst,

	input  int_core_pkg::reg_addr_t w_addr,
	input  int_core_pkg::word_t     w_data,
	input  wire                     w_ena,

	input  int_core_pkg::reg_addr_t r_addr1,
	input  wire                     r_ena1,
	output int_core_pkg::word_t     r_data1,

	input  int_core_pkg::reg_addr_t r_addr2,
	input  wire                     r_ena2,
	output int_core_pkg::word_t     r_data2,

	output int_core_pkg::word_t     regs [int_core_pkg::nregs]
);

	import int_core_pkg::*;

	word_t mem [nregs];
	logic  wr_active;

	// x0 is never written, so it stays at its reset value
	assign wr_active = w_ena && (w_addr != '0);

	function automatic word_t read_port(input reg_addr_t addr, input logic ena);
		word_t val;
		if (rst || !ena)
			val = '0;
		else if (wr_active && (addr == w_addr))
			val = w_data; // Same-cycle write goes straight to the reader
		else
			val = mem[addr];
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < nregs; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_active) begin
			mem[w_addr] <= w_data;
		end
	end

	always_comb begin
		r_data1 = read_port(r_addr1, r_ena1);
	end

	always_comb begin
		r_data2 = read_port(r_addr2, r_ena2);
	end

	// Debug view
	assign regs = mem;

endmodule

`default_nettype wire

//--- design/int_core_pkg.sv
`default_nettype none

package int_core_pkg;

	localparam int xlen  = 64;
	localparam int nregs = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [31:0]     inst_t;

	// Major opcodes
	localparam logic [6:0] op_op  = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;

	// SUB shares f3_add and SRA shares f3_srl
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // SUB, SRA
	localparam logic [5:0] f6_base = 6'b000000;  // RV64 shift immediates
	localparam logic [5:0] f6_alt  = 6'b010000;  // SRAI

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b
	} alu_op_t;

endpackage

`default_nettype wire
